/* soc_top.f */
soc_pkg.sv
soc_bus_if.sv
soc_bus_dec.sv
soc_mem.sv
soc_gpio.sv
soc_bus_mux.sv
soc_top.sv
soc_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and decide the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f soc_top.f --top-module soc_top_tb \
  -Mdir obj_dir -o soc_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/soc_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
  exit 0
fi
exit 1

/* soc_top_tb.sv */
/* Directed testbench that acts as the core's load/store port on the plain bus ports.
   Memory is checked only at addresses written here first. The run stops at TIMEOUT cycles. */

`timescale 1ns/1ps

module soc_top_tb;

  localparam int PERIOD  = 40;
  localparam int SETTLE  = PERIOD/4;   // Sample point after a falling-edge drive
  localparam int TIMEOUT = 2000;       // Roughly 150 cycles of tests plus margin
  localparam int NWORDS  = 8;          // Memory words under test
  localparam int PW      = soc_pkg::GPIO_BANKS * soc_pkg::GW;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    bus_vld;
  logic                    bus_wen;
  logic [soc_pkg::DAW-1:0] bus_adr;
  logic [soc_pkg::DBW-1:0] bus_ben;
  logic [soc_pkg::DDW-1:0] bus_wdt;
  logic [soc_pkg::DDW-1:0] bus_rdt;
  logic                    bus_rdy;
  logic [PW-1:0]           gpio_o;
  logic [PW-1:0]           gpio_e;
  logic [PW-1:0]           gpio_i;

  logic [31:0]   lfsr = 32'h95c67122;
  int            cycles = 0;
  int            errors = 0;
  int            checks = 0;
  int            tests = 0;
  int            tests_failed = 0;
  int            test_err0 = 0;        // Error count when current test began
  logic [31:0]   mem_exp [NWORDS];     // Byte-merged memory model
  logic [PW-1:0] gpio_o_exp = '0;
  logic [PW-1:0] gpio_e_exp = '0;

  soc_top u_soc_top (.*);

  always #(PERIOD/2) clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, bus never completed", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);   // Galois taps 32,22,2,1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};   // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [soc_pkg::DAW-1:0] word_adr(input int i);
    return soc_pkg::DAW'(i * 'h44);
  endfunction

  function automatic logic [soc_pkg::DAW-1:0] gpio_adr(input int b, input int unsigned ofs);
    return soc_pkg::DAW'(soc_pkg::GPIO_BASE + b * soc_pkg::GPIO_STRIDE + ofs);
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h exp %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err0) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  // Drives from a falling edge and returns on the accepting edge
  task automatic issue(input logic wen, input logic [soc_pkg::DAW-1:0] adr,
                       input logic [soc_pkg::DBW-1:0] ben, input logic [soc_pkg::DDW-1:0] wdt);
    bus_vld = 1'b1;
    bus_wen = wen;
    bus_adr = adr;
    bus_ben = ben;
    bus_wdt = wdt;
    #(SETTLE);
    while (!bus_rdy) begin   // Hold request until ready
      @(negedge clk);
      #(SETTLE);
    end
    @(posedge clk);
  endtask

  task automatic bus_write(input logic [soc_pkg::DAW-1:0] adr,
                           input logic [soc_pkg::DBW-1:0] ben, input logic [31:0] wdt);
    issue(1'b1, adr, ben, wdt);
    @(negedge clk);
    bus_vld = 1'b0;
  endtask

  task automatic bus_read(input logic [soc_pkg::DAW-1:0] adr, output logic [31:0] rdt);
    issue(1'b0, adr, '1, '0);
    @(negedge clk);
    bus_vld = 1'b0;
    rdt     = bus_rdt;   // Valid the cycle after accept
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_values;
    repeat (3) @(posedge clk);
    @(negedge clk);
    compare("gpio_o", gpio_o, '0);
    compare("gpio_e", gpio_e, '0);
    compare("bus_rdy", 32'(bus_rdy), 32'h0);   // Memory is selected and held in reset
    rst_n = 1'b1;
    #(SETTLE);
    while (!bus_rdy) begin
      @(negedge clk);
      #(SETTLE);
    end
    compare("bus_rdt", bus_rdt, '0);
    @(negedge clk);   // Next request starts on a falling edge
  endtask

  task automatic memory_bytes;
    logic [31:0] v;
    logic [31:0] got;
    int          lane;
    for (int i = 0; i < NWORDS; i++) begin
      rand_bits(32, v);
      mem_exp[i] = v;
      bus_write(word_adr(i), 4'hF, v);
    end
    for (int i = 0; i < NWORDS; i += 2) begin   // Single-byte overwrites
      rand_bits(2, v);
      lane = int'(v[1:0]);
      rand_bits(32, v);
      bus_write(word_adr(i), 4'b0001 << lane, v);
      mem_exp[i][8*lane +: 8] = v[8*lane +: 8];
    end
    for (int i = 0; i < NWORDS; i++) begin
      bus_read(word_adr(i), got);
      compare("bus_rdt", got, mem_exp[i]);
    end
  endtask

  task automatic gpio_outputs;
    logic [31:0] v;
    logic [31:0] got;
    for (int b = 0; b < soc_pkg::GPIO_BANKS; b++) begin
      rand_bits(32, v);
      bus_write(gpio_adr(b, soc_pkg::GPIO_REG_OUT), 4'hF, v);
      gpio_o_exp[b*soc_pkg::GW +: soc_pkg::GW] = v[15:0];
      compare("gpio_o", gpio_o, gpio_o_exp);              // Other bank must hold
      rand_bits(32, v);
      bus_write(gpio_adr(b, soc_pkg::GPIO_REG_OE), 4'b0010, v);
      gpio_e_exp[b*soc_pkg::GW+8 +: 8] = v[15:8];         // Upper byte only
      compare("gpio_e", gpio_e, gpio_e_exp);
      rand_bits(32, v);
      bus_write(gpio_adr(b, soc_pkg::GPIO_REG_OUT), 4'b0001, v);
      gpio_o_exp[b*soc_pkg::GW +: 8] = v[7:0];
      compare("gpio_o", gpio_o, gpio_o_exp);
    end
    for (int b = 0; b < soc_pkg::GPIO_BANKS; b++) begin
      bus_read(gpio_adr(b, soc_pkg::GPIO_REG_OUT), got);
      compare("bus_rdt", got, 32'(gpio_o_exp[b*soc_pkg::GW +: soc_pkg::GW]));
      bus_read(gpio_adr(b, soc_pkg::GPIO_REG_OE), got);
      compare("bus_rdt", got, 32'(gpio_e_exp[b*soc_pkg::GW +: soc_pkg::GW]));
    end
  endtask

  task automatic gpio_inputs;
    logic [31:0] v;
    logic [31:0] w;
    logic [31:0] got;
    rand_bits(32, v);
    gpio_i = v;
    repeat (4) @(negedge clk);   // Through the synchronizer
    for (int b = 0; b < soc_pkg::GPIO_BANKS; b++) begin
      bus_read(gpio_adr(b, soc_pkg::GPIO_REG_IN), got);
      compare("bus_rdt", got, 32'(v[b*soc_pkg::GW +: soc_pkg::GW]));
      rand_bits(32, w);
      bus_write(gpio_adr(b, soc_pkg::GPIO_REG_IN), 4'hF, w);   // Read-only register
      bus_read(gpio_adr(b, soc_pkg::GPIO_REG_IN), got);
      compare("bus_rdt", got, 32'(v[b*soc_pkg::GW +: soc_pkg::GW]));
    end
  endtask

  task automatic unmapped_access;
    logic [31:0] v;
    logic [31:0] w;
    logic [31:0] got;
    rand_bits(32, v);
    bus_write(12'h400, 4'hF, v);   // Word that 0xC00 aliases in the memory index
    bus_read(12'hC00, got);
    compare("bus_rdt", got, '0);
    bus_read(soc_pkg::DAW'(soc_pkg::GPIO_END), got);
    compare("bus_rdt", got, '0);
    rand_bits(32, w);
    bus_write(12'hC00, 4'hF, w);
    bus_write(soc_pkg::DAW'(soc_pkg::GPIO_END), 4'hF, w);
    bus_read(12'h400, got);
    compare("bus_rdt", got, v);
    compare("gpio_o", gpio_o, gpio_o_exp);
    compare("gpio_e", gpio_e, gpio_e_exp);
  endtask

  task automatic back_to_back_reads;
    logic [31:0] got;
    int          c0;
    issue(1'b0, word_adr(1), '1, '0);                   // Memory read
    @(negedge clk);
    compare("bus_rdt", bus_rdt, mem_exp[1]);
    c0 = cycles;
    issue(1'b0, gpio_adr(0, soc_pkg::GPIO_REG_OUT), '1, '0);   // GPIO read next cycle
    @(negedge clk);
    bus_vld = 1'b0;
    got     = bus_rdt;
    compare("bus_rdt", got, 32'(gpio_o_exp[soc_pkg::GW-1:0]));
    compare("return spacing", 32'(cycles - c0), 32'h1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n   = 1'b0;
    bus_vld = 1'b0;
    bus_wen = 1'b0;
    bus_adr = '0;
    bus_ben = '0;
    bus_wdt = '0;
    gpio_i  = '0;
    reset_values;
    end_test("reset state");
    memory_bytes;
    end_test("memory");
    gpio_outputs;
    end_test("gpio outputs");
    gpio_inputs;
    end_test("gpio inputs");
    unmapped_access;
    end_test("unmapped space");
    back_to_back_reads;
    end_test("back-to-back reads");
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* soc_top.sv */
/* Peripheral side of the SoC with the load/store bus as plain ports.
   One read in flight per target plus one returning; targets never stall after reset. */

`timescale 1ns/1ps

module soc_top (
  input  logic                                       clk,
  input  logic                                       rst_n,
  // Load/store bus
  input  logic                                       bus_vld,
  input  logic                                       bus_wen,
  input  logic [soc_pkg::DAW-1:0]                    bus_adr,
  input  logic [soc_pkg::DBW-1:0]                    bus_ben,
  input  logic [soc_pkg::DDW-1:0]                    bus_wdt,
  output logic [soc_pkg::DDW-1:0]                    bus_rdt,
  output logic                                       bus_rdy,
  // GPIO pins, bank n in slice n
  output logic [soc_pkg::GPIO_BANKS*soc_pkg::GW-1:0] gpio_o,
  output logic [soc_pkg::GPIO_BANKS*soc_pkg::GW-1:0] gpio_e,
  input  logic [soc_pkg::GPIO_BANKS*soc_pkg::GW-1:0] gpio_i
);

  soc_bus_if #(.AW (soc_pkg::DAW), .DW (soc_pkg::DDW)) bus_sys (.clk (clk), .rst_n (rst_n));
  soc_bus_if #(.AW (soc_pkg::DAW), .DW (soc_pkg::DDW)) bus_tgt [soc_pkg::TARGETS-2:0]
    (.clk (clk), .rst_n (rst_n));

  logic [soc_pkg::TARGETS-1:0] sel;
  logic [soc_pkg::DDW-1:0]     rdt_tgt [soc_pkg::TARGETS-2:0];

  // Plain ports onto the system bus
  assign bus_sys.vld = bus_vld;
  assign bus_sys.wen = bus_wen;
  assign bus_sys.adr = bus_adr;
  assign bus_sys.ben = bus_ben;
  assign bus_sys.wdt = bus_wdt;
  assign bus_rdt     = bus_sys.rdt;
  assign bus_rdy     = bus_sys.rdy;

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////////////////////////

  soc_bus_dec u_dec (.bus (bus_sys), .tgt (bus_tgt), .sel (sel));

  soc_bus_mux u_mux (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (sel),
    .bus     (bus_sys),
    .rdt_tgt (rdt_tgt)
  );

  //////////////////////////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////////////////////////

  soc_mem u_mem (.clk (clk), .rst_n (rst_n), .bus (bus_tgt[soc_pkg::TGT_MEM]));
  assign rdt_tgt[soc_pkg::TGT_MEM] = bus_tgt[soc_pkg::TGT_MEM].rdt;

  for (genvar g = 0; g < soc_pkg::GPIO_BANKS; g++) begin : g_gpio
    soc_gpio u_gpio (
      .clk    (clk),
      .rst_n  (rst_n),
      .bus    (bus_tgt[soc_pkg::TGT_GPIO+g]),
      .gpio_o (gpio_o[g*soc_pkg::GW +: soc_pkg::GW]),
      .gpio_e (gpio_e[g*soc_pkg::GW +: soc_pkg::GW]),
      .gpio_i (gpio_i[g*soc_pkg::GW +: soc_pkg::GW])
    );
    assign rdt_tgt[soc_pkg::TGT_GPIO+g] = bus_tgt[soc_pkg::TGT_GPIO+g].rdt;
  end

endmodule

/* soc_bus_mux.sv */
/* Read-return mux: remembers the target of each accepted read for one cycle.
   Returns zero after writes, idle cycles and unmapped reads. */

`timescale 1ns/1ps

module soc_bus_mux (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [soc_pkg::TARGETS-1:0] sel,                          // From decoder
  soc_bus_if.sub                      bus,                          // vld, rdy, wen, rdt
  input  logic [soc_pkg::DDW-1:0]     rdt_tgt [soc_pkg::TARGETS-2:0] // Mapped target data
);

  logic [soc_pkg::TARGETS-1:0] sel_q;   // Target answering this cycle
  logic                        rd_acc;
  logic [soc_pkg::DDW-1:0]     rdt;

  assign rd_acc = bus.vld & bus.rdy & ~bus.wen;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
    end else begin
      sel_q <= rd_acc ? sel : '0;   // Cleared when no read taken
    end
  end

  // AND-OR select; unmapped bit has no data lane so reads zero
  always_comb begin
    rdt = '0;
    for (int t = 0; t < soc_pkg::TARGETS-1; t++) begin
      rdt |= {soc_pkg::DDW{sel_q[t]}} & rdt_tgt[t];
    end
  end

  assign bus.rdt = rdt;

  // At most one target drives the return
  a_selq_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(sel_q));

endmodule

/* soc_gpio.sv */
/* One GPIO bank with output, output-enable and synchronized input registers.
   Only the low GW/8 byte lanes reach the registers. Writes to GPIO_REG_IN are ignored. */

`timescale 1ns/1ps

module soc_gpio (
  input  logic                   clk,
  input  logic                   rst_n,
  soc_bus_if.sub                 bus,
  output logic [soc_pkg::GW-1:0] gpio_o,   // Output values
  output logic [soc_pkg::GW-1:0] gpio_e,   // Output enables
  input  logic [soc_pkg::GW-1:0] gpio_i    // Asynchronous pin inputs
);

  typedef logic [soc_pkg::GPIO_OFS_W-1:0] ofs_t;

  ofs_t                    ofs;         // Bank-local byte offset
  logic                    acc;
  logic                    wr;
  logic                    rdy;
  logic [soc_pkg::DDW-1:0] rdt;
  logic [soc_pkg::GW-1:0]  gpio_meta;   // First sync stage
  logic [soc_pkg::GW-1:0]  gpio_sync;   // Input register seen by the bus

  assign ofs = bus.adr[soc_pkg::GPIO_OFS_W-1:0];
  assign acc = bus.vld & rdy;
  assign wr  = acc & bus.wen;

  ////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;   // Pins tri-stated out of reset
    end else if (wr) begin
      for (int b = 0; b < soc_pkg::GW/8; b++) begin
        if (bus.ben[b] && ofs == ofs_t'(soc_pkg::GPIO_REG_OUT)) begin
          gpio_o[8*b +: 8] <= bus.wdt[8*b +: 8];
        end
        if (bus.ben[b] && ofs == ofs_t'(soc_pkg::GPIO_REG_OE)) begin
          gpio_e[8*b +: 8] <= bus.wdt[8*b +: 8];
        end
      end
    end
  end

  // Two-flop synchronizer on the pins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= gpio_i;
      gpio_sync <= gpio_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Read path and handshake
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (acc & ~bus.wen) begin
      case (ofs)
        ofs_t'(soc_pkg::GPIO_REG_OUT): rdt <= soc_pkg::DDW'(gpio_o);
        ofs_t'(soc_pkg::GPIO_REG_OE):  rdt <= soc_pkg::DDW'(gpio_e);
        ofs_t'(soc_pkg::GPIO_REG_IN):  rdt <= soc_pkg::DDW'(gpio_sync);
        default:                       rdt <= '0;   // Holes read zero
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rdy <= 1'b0;
    else        rdy <= 1'b1;
  end

  assign bus.rdy = rdy;
  assign bus.rdt = rdt;

  // A write to the input offset leaves every register as it was
  a_in_ro: assert property (@(posedge clk) disable iff (!rst_n)
    (wr && ofs == ofs_t'(soc_pkg::GPIO_REG_IN)) |=> ($stable(gpio_o) && $stable(gpio_e)));

endmodule

/* soc_mem.sv */
/* Word-organized data memory, one-cycle registered read, byte-enable writes.
   Contents are undefined after power-up; sub-word address bits are ignored. */

`timescale 1ns/1ps

module soc_mem (
  input logic    clk,
  input logic    rst_n,
  soc_bus_if.sub bus
);

  logic [soc_pkg::DDW-1:0]    mem [soc_pkg::MEM_WORDS];
  logic [soc_pkg::MEM_AW-1:0] idx;      // Word index
  logic                       acc;      // Transfer this cycle
  logic                       rdy;
  logic [soc_pkg::DDW-1:0]    rdt;

  assign idx = bus.adr[soc_pkg::BSW +: soc_pkg::MEM_AW];
  assign acc = bus.vld & rdy;

  ////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////

  // Write lands on the accepting edge
  always_ff @(posedge clk) begin
    if (acc & bus.wen) begin
      for (int b = 0; b < soc_pkg::DBW; b++) begin
        if (bus.ben[b]) mem[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
      end
    end
  end

  // Read word registered, valid next cycle
  always_ff @(posedge clk) begin
    if (acc & ~bus.wen) rdt <= mem[idx];
  end

  ////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;    // Ready from first edge after reset
    end
  end

  assign bus.rdy = rdy;
  assign bus.rdt = rdt;

endmodule

/* soc_bus_dec.sv */
/* Routes one request to memory, a GPIO bank or the unmapped sink.
   The unmapped sink is always ready and its read data is zero, supplied by the return mux. */

`timescale 1ns/1ps

module soc_bus_dec (
  soc_bus_if.sub bus,                                   // From load/store port
  soc_bus_if.man tgt [soc_pkg::TARGETS-2:0],            // Mapped targets
  output logic [soc_pkg::TARGETS-1:0] sel               // One-hot target select
);

  typedef logic [soc_pkg::DAW-soc_pkg::GPIO_OFS_W-1:0] bnk_t;

  bnk_t                         gpio_bnk;   // Bank number inside GPIO region
  logic [soc_pkg::TARGETS-1:0]  rdy_tgt;

  ////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////

  assign gpio_bnk = bus.adr[soc_pkg::DAW-1:soc_pkg::GPIO_OFS_W]
                  - bnk_t'(soc_pkg::GPIO_BASE >> soc_pkg::GPIO_OFS_W);

  always_comb begin
    sel = '0;
    if (bus.adr < soc_pkg::DAW'(soc_pkg::MEM_END)) begin
      sel[soc_pkg::TGT_MEM] = 1'b1;
    end else if (bus.adr < soc_pkg::DAW'(soc_pkg::GPIO_END)) begin
      // Region below GPIO_END is fully covered by banks
      for (int unsigned i = 0; i < soc_pkg::GPIO_BANKS; i++) begin
        if (gpio_bnk == bnk_t'(i)) sel[soc_pkg::TGT_GPIO+i] = 1'b1;
      end
    end else begin
      sel[soc_pkg::TGT_UNM] = 1'b1;   // 0xC00 up and past last bank
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Request fan-out and ready return
  ////////////////////////////////////////////////////////////////////////

  for (genvar t = 0; t < soc_pkg::TARGETS-1; t++) begin : g_tgt
    assign tgt[t].vld = bus.vld & sel[t];   // Only chosen target sees vld
    assign tgt[t].wen = bus.wen;
    assign tgt[t].adr = bus.adr;
    assign tgt[t].ben = bus.ben;
    assign tgt[t].wdt = bus.wdt;
    assign rdy_tgt[t] = tgt[t].rdy;
  end

  assign rdy_tgt[soc_pkg::TGT_UNM] = 1'b1;  // Sink never stalls

  assign bus.rdy = |(sel & rdy_tgt);

  // Exactly one target owns every request
  a_sel_onehot: assert property (@(posedge bus.clk) disable iff (!bus.rst_n)
    bus.vld |-> $onehot(sel));

endmodule

/* soc_bus_if.sv */
/* System bus with the load/store handshake: transfer when vld and rdy are both high.
   Read data follows one cycle after the accepting edge. */

`timescale 1ns/1ps

interface soc_bus_if #(
  int unsigned AW = 12,   // Byte address width
  int unsigned DW = 32    // Data width
)(
  input logic clk,
  input logic rst_n
);

  logic            vld;   // Request valid
  logic            wen;   // Write enable, read when low
  logic [AW-1:0]   adr;   // Byte address
  logic [DW/8-1:0] ben;   // Byte enables
  logic [DW-1:0]   wdt;   // Write data
  logic [DW-1:0]   rdt;   // Read data, cycle after accept
  logic            rdy;   // Ready

  // Load/store side
  modport man (
    input  clk, rst_n,
    output vld, wen, adr, ben, wdt,
    input  rdt, rdy
  );

  // Target side
  modport sub (
    input  clk, rst_n,
    input  vld, wen, adr, ben, wdt,
    output rdt, rdy
  );

endinterface

/* soc_pkg.sv */
/* Bus widths, address map and target indexing for the peripheral bus.
   The GPIO decode assumes GPIO_STRIDE is a power of two and the GPIO region ends below 0xC00. */

package soc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DDW = 32;              // Data width
  localparam int unsigned DBW = DDW/8;           // Byte enables
  localparam int unsigned BSW = $clog2(DBW);     // Byte offset bits in an address
  localparam int unsigned DAW = 12;              // Byte address width

  //////////////////////////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned GW         = 16;              // Pins per GPIO bank
  localparam int unsigned GPIO_BANKS = 2;
  localparam int unsigned TARGETS    = GPIO_BANKS + 2;  // Memory, banks, unmapped
  localparam int unsigned TGT_MEM    = 0;
  localparam int unsigned TGT_GPIO   = 1;               // First GPIO bank
  localparam int unsigned TGT_UNM    = TARGETS - 1;     // Built-in error-free sink

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////

  // Data memory from 0x000
  localparam int unsigned MEM_WORDS = 512;
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);  // Word index bits
  localparam int unsigned MEM_END   = MEM_WORDS * DBW;    // First byte past memory

  // GPIO banks, one per stride
  localparam int unsigned GPIO_BASE   = 'h800;
  localparam int unsigned GPIO_STRIDE = 'h10;
  localparam int unsigned GPIO_OFS_W  = $clog2(GPIO_STRIDE);  // Bank-local offset bits
  localparam int unsigned GPIO_END    = GPIO_BASE + GPIO_BANKS * GPIO_STRIDE;

  // Bank-local register offsets, others read zero
  localparam int unsigned GPIO_REG_OUT = 'h0;
  localparam int unsigned GPIO_REG_OE  = 'h4;
  localparam int unsigned GPIO_REG_IN  = 'h8;

endpackage
